// ==== common/execute_config.svh ====
`ifndef EXECUTE_CONFIG_SVH
`define EXECUTE_CONFIG_SVH

// Data and address width.
`define XLEN 32

`define BYTE_LANES (`XLEN / 8)

// One load cycle, then one cycle per quotient bit.
`define DIV_CYCLES (`XLEN + 1)

// Low address bits that must be zero per access size.
`define HALF_ALIGN_MASK 2'b01
`define WORD_ALIGN_MASK 2'b11

// No compressed instructions.
`define INST_ALIGN_MASK 2'b11

`endif

// ==== common/isa_pkg.sv ====
package isa_pkg;

    // funct7[5] with funct3.
    typedef enum logic [3:0] {
        alu_add  = 4'b0000,
        alu_sub  = 4'b1000,
        alu_sll  = 4'b0001,
        alu_slt  = 4'b0010,
        alu_sltu = 4'b0011,
        alu_xor  = 4'b0100,
        alu_srl  = 4'b0101,
        alu_sra  = 4'b1101,
        alu_or   = 4'b0110,
        alu_and  = 4'b0111
    } alu_op_t;

    typedef enum logic [2:0] {
        bcu_beq  = 3'b000,
        bcu_bne  = 3'b001,
        bcu_blt  = 3'b100,
        bcu_bge  = 3'b101,
        bcu_bltu = 3'b110,
        bcu_bgeu = 3'b111
    } bcu_op_t;

    typedef enum logic [2:0] {
        lsu_lb  = 3'b000,
        lsu_lh  = 3'b001,
        lsu_lw  = 3'b010,
        lsu_lbu = 3'b100,
        lsu_lhu = 3'b101
    } lsu_op_t;

    typedef enum logic [1:0] {
        div_div  = 2'b00,
        div_divu = 2'b01,
        div_rem  = 2'b10,
        div_remu = 2'b11
    } div_op_t;

    // Machine cause codes.
    typedef enum logic [3:0] {
        except_instr_misaligned = 4'd0,
        except_illegal_instr    = 4'd2,
        except_breakpoint       = 4'd3,
        except_load_misaligned  = 4'd4,
        except_store_misaligned = 4'd6,
        except_env_call_mach    = 4'd11
    } except_cause_t;

endpackage

// ==== common/execute_pkg.sv ====
`include "execute_config.svh"

package execute_pkg;
    import isa_pkg::*;

    typedef struct packed {
        logic wren;
        logic sel_imm;
        logic lui;
        logic auipc;
        logic jal;
        logic jalr;
        logic branch;
        logic load;
        logic store;
        logic divide;
        logic illegal;
        logic ebreak;
        logic ecall;
    } op_flags_t;

    typedef struct packed {
        logic valid;
        op_flags_t op;
        alu_op_t alu_op;
        bcu_op_t bcu_op;
        lsu_op_t lsu_op;
        div_op_t div_op;
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] npc;
        logic [`XLEN-1:0] instr;
        logic [`XLEN-1:0] rdata1;
        logic [`XLEN-1:0] rdata2;
        logic [`XLEN-1:0] imm;
        logic [4:0] waddr;
    } lane_in_t;

    typedef struct packed {
        lane_in_t lane0;
        lane_in_t lane1;
    } issue_pair_t;

    typedef struct packed {
        logic valid;
        logic wren;
        logic [4:0] waddr;
        logic [`XLEN-1:0] wdata;
        logic jump;
        logic [`XLEN-1:0] target;
        logic load;
        logic store;
        logic [`XLEN-1:0] address;
        logic [`BYTE_LANES-1:0] byteenable;
        logic [`XLEN-1:0] sdata;
        logic exception;
        except_cause_t ecause;
        logic [`XLEN-1:0] etval;
    } lane_result_t;

    typedef struct packed {
        lane_result_t lane0;
        lane_result_t lane1;
    } execute_out_t;

    typedef struct packed {
        logic start;
        div_op_t div_op;
        logic [`XLEN-1:0] dividend;
        logic [`XLEN-1:0] divisor;
    } div_req_t;

    typedef struct packed {
        logic ready;
        logic [`XLEN-1:0] result;
    } div_resp_t;

    typedef enum logic [1:0] {
        div_idle,
        div_run,
        div_done
    } div_state_t;

    localparam lane_result_t init_lane_result = '0;
    localparam execute_out_t init_execute_out = '0;

endpackage

// ==== verilog/execute_lane.sv ====
`timescale 1ns/100ps
`include "execute_config.svh"

module execute_lane (
    input execute_pkg::lane_in_t lane,
    input logic [`XLEN-1:0] div_result,
    output execute_pkg::div_req_t div_req,
    output execute_pkg::lane_result_t res
);
    import isa_pkg::*;
    import execute_pkg::*;

    localparam int SHW = $clog2(`XLEN);

    logic [`XLEN-1:0] op2;
    logic [SHW-1:0] shamt;
    logic [`XLEN-1:0] alu_result;
    logic taken;
    logic [`XLEN-1:0] address;
    logic [`XLEN-1:0] pc_imm;
    logic [`XLEN-1:0] target;
    logic [`BYTE_LANES-1:0] byte_mask;
    logic misaligned;

    always_comb begin
        op2 = lane.op.sel_imm ? lane.imm : lane.rdata2;
        shamt = op2[SHW-1:0];
        case (lane.alu_op)
            alu_add:  alu_result = lane.rdata1 + op2;
            alu_sub:  alu_result = lane.rdata1 - op2;
            alu_sll:  alu_result = lane.rdata1 << shamt;
            alu_slt:  alu_result = {{(`XLEN-1){1'b0}}, $signed(lane.rdata1) < $signed(op2)};
            alu_sltu: alu_result = {{(`XLEN-1){1'b0}}, lane.rdata1 < op2};
            alu_xor:  alu_result = lane.rdata1 ^ op2;
            alu_srl:  alu_result = lane.rdata1 >> shamt;
            alu_sra:  alu_result = $signed(lane.rdata1) >>> shamt;
            alu_or:   alu_result = lane.rdata1 | op2;
            alu_and:  alu_result = lane.rdata1 & op2;
            default:  alu_result = '0;
        endcase
    end

    always_comb begin
        case (lane.bcu_op)
            bcu_beq:  taken = lane.rdata1 == lane.rdata2;
            bcu_bne:  taken = lane.rdata1 != lane.rdata2;
            bcu_blt:  taken = $signed(lane.rdata1) < $signed(lane.rdata2);
            bcu_bge:  taken = $signed(lane.rdata1) >= $signed(lane.rdata2);
            bcu_bltu: taken = lane.rdata1 < lane.rdata2;
            bcu_bgeu: taken = lane.rdata1 >= lane.rdata2;
            default:  taken = 1'b0;
        endcase
    end

    always_comb begin
        address = lane.rdata1 + lane.imm;
        pc_imm = lane.pc + lane.imm;
        target = lane.op.jalr ? {address[`XLEN-1:1], 1'b0} : pc_imm; // Jalr drops bit 0.
        case (lane.lsu_op)
            lsu_lb, lsu_lbu: begin
                byte_mask = 'b0001;
                misaligned = 1'b0;
            end
            lsu_lh, lsu_lhu: begin
                byte_mask = 'b0011;
                misaligned = |(address[1:0] & `HALF_ALIGN_MASK);
            end
            default: begin
                byte_mask = '1;
                misaligned = |(address[1:0] & `WORD_ALIGN_MASK);
            end
        endcase
    end

    // Divide present in this lane.
    assign div_req.start = lane.valid & lane.op.divide;
    assign div_req.div_op = lane.div_op;
    assign div_req.dividend = lane.rdata1;
    assign div_req.divisor = lane.rdata2;

    always_comb begin
        res = init_lane_result;
        if (lane.valid) begin
            res.valid = 1'b1;
            res.wren = lane.op.wren;
            res.waddr = lane.waddr;
            res.jump = lane.op.jal | lane.op.jalr | (lane.op.branch & taken);
            res.target = target;
            res.load = lane.op.load;
            res.store = lane.op.store;
            res.address = address;
            res.byteenable = byte_mask << address[1:0];
            res.sdata = lane.rdata2 << {address[1:0], 3'b000}; // Aligned into its byte lane.

            if (lane.op.auipc) begin
                res.wdata = pc_imm;
            end else if (lane.op.lui) begin
                res.wdata = lane.imm;
            end else if (lane.op.jal | lane.op.jalr) begin
                res.wdata = lane.npc; // Link address.
            end else if (lane.op.divide) begin
                res.wdata = div_result;
            end else begin
                res.wdata = alu_result;
            end

            if (lane.op.illegal) begin
                res.exception = 1'b1;
                res.ecause = except_illegal_instr;
                res.etval = lane.instr;
            end else if (lane.op.ebreak) begin
                res.exception = 1'b1;
                res.ecause = except_breakpoint;
                res.etval = lane.instr;
            end else if (lane.op.ecall) begin
                res.exception = 1'b1;
                res.ecause = except_env_call_mach;
                res.etval = lane.instr;
            end else if (lane.op.load & misaligned) begin
                res.exception = 1'b1;
                res.ecause = except_load_misaligned;
                res.etval = address;
                res.load = 1'b0;
                res.wren = 1'b0;
            end else if (lane.op.store & misaligned) begin
                res.exception = 1'b1;
                res.ecause = except_store_misaligned;
                res.etval = address;
                res.store = 1'b0;
            end else if (res.jump & |(target[1:0] & `INST_ALIGN_MASK)) begin
                res.exception = 1'b1;
                res.ecause = except_instr_misaligned;
                res.etval = target;
                res.jump = 1'b0;
                res.wren = 1'b0;
            end
        end
    end

endmodule

// ==== verilog/int_divider.sv ====
`timescale 1ns/100ps
`include "execute_config.svh"

module int_divider (
    input logic clock,
    input logic reset,
    input execute_pkg::div_req_t req,
    output execute_pkg::div_resp_t resp
);
    import isa_pkg::*;
    import execute_pkg::*;

    localparam int CW = $clog2(`DIV_CYCLES);

    div_state_t state;
    div_op_t op;
    logic [`XLEN-1:0] quotient;
    logic [`XLEN-1:0] remainder;
    logic [`XLEN-1:0] divisor;
    logic [CW-1:0] count;
    logic neg_q;
    logic neg_r;
    logic is_signed;
    logic a_neg;
    logic b_neg;
    logic [`XLEN:0] shifted;
    logic [`XLEN:0] diff;

    assign is_signed = (req.div_op == div_div) || (req.div_op == div_rem);
    assign a_neg = is_signed & req.dividend[`XLEN-1];
    assign b_neg = is_signed & req.divisor[`XLEN-1];

    // One restoring step.
    assign shifted = {remainder, quotient[`XLEN-1]};
    assign diff = shifted - {1'b0, divisor};

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= div_idle;
        end else begin
            case (state)
                div_run: if (count == CW'(1)) state <= div_done;
                default: if (req.start) state <= div_run;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (req.start) begin
            op <= req.div_op;
            quotient <= a_neg ? -req.dividend : req.dividend;
            divisor <= b_neg ? -req.divisor : req.divisor;
            remainder <= '0;
            count <= CW'(`DIV_CYCLES - 1);
            neg_q <= (a_neg ^ b_neg) & (|req.divisor); // Zero divisor keeps all ones.
            neg_r <= a_neg;
        end else if (state == div_run) begin
            quotient <= {quotient[`XLEN-2:0], ~diff[`XLEN]};
            remainder <= diff[`XLEN] ? shifted[`XLEN-1:0] : diff[`XLEN-1:0];
            count <= count - CW'(1);
        end
    end

    // Sign fix-up on the way out.
    always_comb begin
        resp.ready = state == div_done;
        if (op == div_div || op == div_divu) begin
            resp.result = neg_q ? -quotient : quotient;
        end else begin
            resp.result = neg_r ? -remainder : remainder;
        end
    end

    a_start_idle: assert property (@(posedge clock) disable iff (!reset)
        req.start |-> state != div_run);

endmodule

// ==== verilog/execute_stage.sv ====
`timescale 1ns/100ps

module execute_stage (
    input logic clock,
    input logic reset,
    input execute_pkg::issue_pair_t issue,
    input logic hold,
    input logic flush,
    output logic stall,
    output execute_pkg::execute_out_t result
);
    import execute_pkg::*;

    div_req_t req0;
    div_req_t req1;
    div_req_t div_req;
    div_resp_t div_resp;
    lane_result_t res0;
    lane_result_t res1;
    execute_out_t next;
    logic div_pending;
    logic div_owned;   // Divider works for the pair on issue.
    logic div_busy;
    logic div_running;

    execute_lane lane0 (
        .lane(issue.lane0),
        .div_result(div_resp.result),
        .div_req(req0),
        .res(res0)
    );

    execute_lane lane1 (
        .lane(issue.lane1),
        .div_result(div_resp.result),
        .div_req(req1),
        .res(res1)
    );

    int_divider divider (
        .clock(clock),
        .reset(reset),
        .req(div_req),
        .resp(div_resp)
    );

    assign div_pending = req0.start | req1.start;
    assign div_running = div_busy & ~div_resp.ready;

    always_comb begin
        div_req = req0.start ? req0 : req1; // Lane 0 first.
        div_req.start = div_pending & ~div_owned & ~div_running & ~hold & ~flush;
    end

    // Held until the owned divide reports ready.
    assign stall = div_pending & ~(div_owned & div_resp.ready);

    always_ff @(posedge clock) begin
        if (!reset) begin
            div_owned <= 1'b0;
            div_busy <= 1'b0;
        end else if (div_req.start) begin
            div_owned <= 1'b1;
            div_busy <= 1'b1;
        end else begin
            if (div_resp.ready) div_busy <= 1'b0;
            // A flushed divide runs on but its result is dropped.
            if (flush || (div_resp.ready && !hold)) div_owned <= 1'b0;
        end
    end

    always_comb begin
        next.lane0 = res0;
        next.lane1 = res1;
        if (res0.jump | res0.exception) begin
            next.lane1 = init_lane_result; // Younger lane is on the wrong path.
        end
        if (stall | flush) begin
            next.lane0 = init_lane_result;
            next.lane1 = init_lane_result;
        end
    end

    // Flush wins over hold.
    always_ff @(posedge clock) begin
        if (!reset) begin
            result <= init_execute_out;
        end else if (flush || !hold) begin
            result <= next;
        end
    end

    a_single_divide: assert property (@(posedge clock) disable iff (!reset)
        !(req0.start && req1.start));

endmodule

// ==== bench/execute_stage_tb.sv ====
`timescale 1ns/100ps
`include "execute_config.svh"

module execute_stage_tb;
    import isa_pkg::*;
    import execute_pkg::*;

    localparam int DIV_TIMEOUT = 4 * `DIV_CYCLES;
    localparam logic [`XLEN-1:0] MOST_NEG = {1'b1, {(`XLEN-1){1'b0}}};

    logic clock;
    logic reset;
    logic hold;
    logic flush;
    logic stall;
    issue_pair_t issue;
    execute_out_t result;

    execute_out_t exp_out;
    logic armed = 1'b0;
    string test_name = "reset";
    int checks = 0;
    int errors = 0;
    int tests = 0;
    int mark_checks = 0;
    int mark_errors = 0;

    alu_op_t alu_ops[$] = '{alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
                            alu_xor, alu_srl, alu_sra, alu_or, alu_and};
    bcu_op_t bcu_ops[$] = '{bcu_beq, bcu_bne, bcu_blt, bcu_bge, bcu_bltu, bcu_bgeu};
    lsu_op_t lsu_ops[$] = '{lsu_lb, lsu_lh, lsu_lw, lsu_lbu, lsu_lhu};
    div_op_t div_ops[$] = '{div_div, div_divu, div_rem, div_remu};

    execute_stage dut (
        .clock(clock),
        .reset(reset),
        .issue(issue),
        .hold(hold),
        .flush(flush),
        .stall(stall),
        .result(result)
    );

    always #5 clock = ~clock;

    function automatic logic [`XLEN-1:0] alu_ref(input alu_op_t op,
                                                 input logic [`XLEN-1:0] a,
                                                 input logic [`XLEN-1:0] b);
        case (op)
            alu_add:  return a + b;
            alu_sub:  return a - b;
            alu_sll:  return a << b[4:0];
            alu_slt:  return ($signed(a) < $signed(b)) ? 1 : 0;
            alu_sltu: return (a < b) ? 1 : 0;
            alu_xor:  return a ^ b;
            alu_srl:  return a >> b[4:0];
            alu_sra:  return $signed(a) >>> b[4:0];
            alu_or:   return a | b;
            alu_and:  return a & b;
            default:  return '0;
        endcase
    endfunction

    function automatic logic branch_ref(input bcu_op_t op, input logic [`XLEN-1:0] a,
                                        input logic [`XLEN-1:0] b);
        case (op)
            bcu_beq:  return a == b;
            bcu_bne:  return a != b;
            bcu_blt:  return $signed(a) < $signed(b);
            bcu_bge:  return $signed(a) >= $signed(b);
            bcu_bltu: return a < b;
            bcu_bgeu: return a >= b;
            default:  return 1'b0;
        endcase
    endfunction

    // Division with the RISC-V zero and overflow rules.
    function automatic logic [`XLEN-1:0] div_ref(input div_op_t op, input logic [`XLEN-1:0] a,
                                                 input logic [`XLEN-1:0] b);
        logic [`XLEN-1:0] r;
        logic ovf;
        ovf = (a == MOST_NEG) && (b == '1);
        if (op == div_div || op == div_divu) begin
            if (b == '0) r = '1;
            else if (op == div_divu) r = a / b;
            else if (ovf) r = a;
            else r = $signed(a) / $signed(b);
        end else begin
            if (b == '0) r = a;
            else if (op == div_remu) r = a % b;
            else if (ovf) r = '0;
            else r = $signed(a) % $signed(b);
        end
        return r;
    endfunction

    function automatic lane_result_t lane_ref(input lane_in_t l);
        lane_result_t r;
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] tgt;
        logic [3:0] size_mask;
        logic misaligned;
        r = '0;
        if (l.valid) begin
            addr = l.rdata1 + l.imm;
            tgt = l.op.jalr ? (addr & ~32'h1) : l.pc + l.imm;
            case (l.lsu_op)
                lsu_lb, lsu_lbu: size_mask = 4'b0001;
                lsu_lh, lsu_lhu: size_mask = 4'b0011;
                default:         size_mask = 4'b1111;
            endcase
            misaligned = (size_mask == 4'b0011 && addr[0]) ||
                         (size_mask == 4'b1111 && addr[1:0] != 2'b00);
            r.valid = 1'b1;
            r.wren = l.op.wren;
            r.waddr = l.waddr;
            r.jump = l.op.jal | l.op.jalr | (l.op.branch & branch_ref(l.bcu_op, l.rdata1, l.rdata2));
            r.target = tgt;
            r.load = l.op.load;
            r.store = l.op.store;
            r.address = addr;
            r.byteenable = size_mask << addr[1:0];
            r.sdata = l.rdata2 << (8 * addr[1:0]);
            if (l.op.auipc) r.wdata = l.pc + l.imm;
            else if (l.op.lui) r.wdata = l.imm;
            else if (l.op.jal | l.op.jalr) r.wdata = l.npc;
            else if (l.op.divide) r.wdata = div_ref(l.div_op, l.rdata1, l.rdata2);
            else r.wdata = alu_ref(l.alu_op, l.rdata1, l.op.sel_imm ? l.imm : l.rdata2);
            r.exception = 1'b1;
            if (l.op.illegal) begin
                r.ecause = except_illegal_instr;
                r.etval = l.instr;
            end else if (l.op.ebreak) begin
                r.ecause = except_breakpoint;
                r.etval = l.instr;
            end else if (l.op.ecall) begin
                r.ecause = except_env_call_mach;
                r.etval = l.instr;
            end else if (l.op.load && misaligned) begin
                r.ecause = except_load_misaligned;
                r.etval = addr;
                r.load = 1'b0;
                r.wren = 1'b0;
            end else if (l.op.store && misaligned) begin
                r.ecause = except_store_misaligned;
                r.etval = addr;
                r.store = 1'b0;
            end else if (r.jump && tgt[1:0] != 2'b00) begin
                r.ecause = except_instr_misaligned;
                r.etval = tgt;
                r.jump = 1'b0;
                r.wren = 1'b0;
            end else begin
                r.exception = 1'b0;
            end
        end
        return r;
    endfunction

    function automatic execute_out_t pair_ref(input issue_pair_t p);
        execute_out_t r;
        r.lane0 = lane_ref(p.lane0);
        r.lane1 = lane_ref(p.lane1);
        if (r.lane0.jump || r.lane0.exception) r.lane1 = '0; // Lane 1 squashed.
        return r;
    endfunction

    function automatic lane_in_t random_lane();
        lane_in_t l;
        l = '0;
        l.valid = 1'b1;
        l.op.wren = 1'b1;
        l.op.sel_imm = ($urandom_range(0, 1) == 1);
        l.alu_op = alu_ops[$urandom_range(0, 9)];
        l.bcu_op = bcu_beq;
        l.lsu_op = lsu_lw;
        l.div_op = div_div;
        l.pc = $urandom & 32'hffff_fffc;
        l.npc = l.pc + 4;
        l.instr = $urandom;
        l.rdata1 = $urandom;
        l.rdata2 = $urandom;
        l.imm = $urandom;
        l.waddr = 5'($urandom);
        return l;
    endfunction

    function automatic lane_in_t control_lane();
        lane_in_t l;
        l = random_lane();
        l.imm = $urandom & 32'hffff_fffc;
        if ($urandom_range(0, 3) == 0) l.imm[1:0] = 2'($urandom_range(1, 3)); // Odd offsets.
        l.rdata1 = $urandom & 32'hffff_fffc;
        case ($urandom_range(0, 3))
            0: begin
                l.op.branch = 1'b1;
                l.op.wren = 1'b0;
                l.bcu_op = bcu_ops[$urandom_range(0, 5)];
                if ($urandom_range(0, 2) == 0) l.rdata2 = l.rdata1;
            end
            1: l.op.jal = 1'b1;
            2: l.op.jalr = 1'b1;
            default: ;
        endcase
        return l;
    endfunction

    function automatic lane_in_t memory_lane();
        lane_in_t l;
        l = random_lane();
        l.lsu_op = lsu_ops[$urandom_range(0, 4)];
        l.imm = $urandom_range(0, 63);
        if ($urandom_range(0, 1) == 1) begin
            l.op.load = 1'b1;
        end else begin
            l.op.store = 1'b1;
            l.op.wren = 1'b0;
        end
        return l;
    endfunction

    function automatic lane_in_t divide_lane(input int kind);
        lane_in_t l;
        l = random_lane();
        l.op.divide = 1'b1;
        l.op.sel_imm = 1'b0;
        l.div_op = div_ops[$urandom_range(0, 3)];
        if (kind == 1) begin
            l.rdata2 = '0;
        end else if (kind == 2) begin
            l.rdata1 = MOST_NEG;
            l.rdata2 = '1;
        end
        return l;
    endfunction

    task automatic compare_value(input string name, input logic [191:0] expected,
                                 input logic [191:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    // Result settles well before the next falling edge.
    always @(posedge clock) begin
        #2;
        if (armed) begin
            armed = 1'b0;
            compare_value({test_name, " lane0"}, 192'(exp_out.lane0), 192'(result.lane0));
            compare_value({test_name, " lane1"}, 192'(exp_out.lane1), 192'(result.lane1));
        end
    end

    task automatic present(input issue_pair_t p, input execute_out_t e);
        @(negedge clock);
        issue = p;
        exp_out = e;
        armed = 1'b1;
    endtask

    task automatic run_divide(input issue_pair_t p);
        int waited;
        @(negedge clock);
        issue = p;
        @(negedge clock);
        compare_value({test_name, " stall"}, 192'(1'b1), 192'(stall));
        compare_value({test_name, " bubble0"}, 192'(init_lane_result), 192'(result.lane0));
        compare_value({test_name, " bubble1"}, 192'(init_lane_result), 192'(result.lane1));
        waited = 0;
        while (stall && waited < DIV_TIMEOUT) begin
            @(negedge clock);
            waited++;
        end
        if (stall) begin
            errors++;
            $display("%s: stall still high after %0d cycles", test_name, waited);
            issue = '0;
        end else begin
            exp_out = pair_ref(p);
            armed = 1'b1;
            @(negedge clock);
            issue = '0; // Keeps the divider from starting again.
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        mark_checks = checks;
        mark_errors = errors;
    endtask

    task automatic end_test();
        @(negedge clock);
        tests++;
        $display("%s: %0d checks, %0d errors", test_name, checks - mark_checks,
                 errors - mark_errors);
    endtask

    initial begin
        issue_pair_t p;
        execute_out_t saved;
        clock = 1'b0;
        reset = 1'b0;
        hold = 1'b0;
        flush = 1'b0;
        issue = '0;
        void'($urandom(62));
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;

        begin_test("reset");
        compare_value("reset lane0", 192'(init_lane_result), 192'(result.lane0));
        compare_value("reset lane1", 192'(init_lane_result), 192'(result.lane1));
        compare_value("reset stall", 192'(1'b0), 192'(stall));
        end_test();

        begin_test("alu");
        repeat (40) begin
            p.lane0 = random_lane();
            p.lane1 = random_lane();
            if ($urandom_range(0, 7) == 0) p.lane0.op.lui = 1'b1;
            if ($urandom_range(0, 7) == 0) p.lane1.op.auipc = 1'b1;
            present(p, pair_ref(p));
        end
        end_test();

        begin_test("control");
        repeat (40) begin
            p.lane0 = control_lane();
            p.lane1 = control_lane();
            present(p, pair_ref(p));
        end
        end_test();

        begin_test("memory");
        repeat (60) begin
            p.lane0 = memory_lane();
            p.lane1 = memory_lane();
            present(p, pair_ref(p));
        end
        end_test();

        begin_test("exception");
        repeat (40) begin
            p.lane0 = memory_lane();
            p.lane0.op.illegal = ($urandom_range(0, 2) == 0);
            p.lane0.op.ebreak = ($urandom_range(0, 2) == 0);
            p.lane0.op.ecall = ($urandom_range(0, 2) == 0);
            p.lane1 = random_lane();
            present(p, pair_ref(p));
        end
        end_test();

        begin_test("divide");
        for (int i = 0; i < 12; i++) begin
            if (i % 2 == 1) begin
                p.lane0 = divide_lane(i % 3);
                p.lane1 = random_lane();
            end else begin
                p.lane0 = random_lane();
                p.lane1 = divide_lane(i % 3);
            end
            run_divide(p);
        end
        end_test();

        begin_test("hold_flush");
        p.lane0 = random_lane();
        p.lane1 = random_lane();
        saved = pair_ref(p);
        present(p, saved);
        repeat (3) begin
            p.lane0 = random_lane();
            p.lane1 = random_lane();
            present(p, saved);
            hold = 1'b1;
        end
        p.lane0 = random_lane();
        present(p, pair_ref(p));
        hold = 1'b0;
        present(p, '0);
        flush = 1'b1;
        hold = 1'b1; // Flush still clears.
        present(p, '0);
        hold = 1'b0;
        present(p, pair_ref(p));
        flush = 1'b0;
        end_test();

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== execute_stage.f ====
+incdir+common
common/isa_pkg.sv
common/execute_pkg.sv
verilog/execute_lane.sv
verilog/int_divider.sv
verilog/execute_stage.sv
bench/execute_stage_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= execute_stage_tb
FILELIST ?= execute_stage.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := common/execute_config.svh
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -qx "Finished with no errors" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
